/* logic/jtag_bridge_top.sv */
//////////////////////////////////////////////////////////////////////
// JTAG bridge top level
// Pin driver, pin bundle and TAP target with plain host ports
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module jtag_bridge_top #(
  parameter logic [5:0]  HALF_PERIOD  = 6'd8,
  parameter logic [31:0] IDCODE_VALUE = 32'h149B_51C3
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            cmd_valid_i,
  input  logic [3:0]                      pin_word_i,
  output logic                            half_period_o,
  output logic                            tdo_o,
  output logic                            tdo_change_o,
  output logic [jtag_pkg::USER_WIDTH-1:0] user_data_o,
  output logic                            user_update_o
);

  import jtag_pkg::*;

  // TAP state and TCK edges from controller to scan registers
  tap_state_t tap_state;
  logic       tck_rise;
  logic       tck_fall;

  // The five JTAG pins
  jtag_pins_if pins ();

  // Host side
  jtag_pin_driver #(
    .HALF_PERIOD   (HALF_PERIOD)
  ) u_pin_driver (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cmd_valid_i   (cmd_valid_i),
    .pin_word_i    (pin_word_i),
    .half_period_o (half_period_o),
    .tdo_o         (tdo_o),
    .tdo_change_o  (tdo_change_o),
    .pins          (pins.driver)
  );

  // Target side
  jtag_tap_ctrl u_tap_ctrl (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .pins       (pins.target),
    .state_o    (tap_state),
    .tck_rise_o (tck_rise),
    .tck_fall_o (tck_fall)
  );

  jtag_scan_regs #(
    .IDCODE_VALUE  (IDCODE_VALUE)
  ) u_scan_regs (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .pins          (pins.target),
    .state_i       (tap_state),
    .tck_rise_i    (tck_rise),
    .tck_fall_i    (tck_fall),
    .user_data_o   (user_data_o),
    .user_update_o (user_update_o)
  );

endmodule

/* logic/jtag_pin_driver.sv */
//////////////////////////////////////////////////////////////////////
// JTAG pin driver
// Holds the host pin word, drives the pins, runs the half-period
// timer and returns TDO with a change strobe
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module jtag_pin_driver #(
  parameter logic [5:0] HALF_PERIOD = 6'd8
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        cmd_valid_i,
  input  logic [3:0]  pin_word_i,
  output logic        half_period_o,
  output logic        tdo_o,
  output logic        tdo_change_o,
  jtag_pins_if.driver pins
);

  logic [3:0] pin_word_q;
  logic [5:0] timer_q;
  logic       timer_run_q;
  logic       timer_done;
  logic       tdo_q;
  logic       tdo_change_q;

  //////////////////////////////////////////////////////////////////////
  // Pin word
  //////////////////////////////////////////////////////////////////////

  // New word replaces the old one, all pins low out of reset
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      pin_word_q <= 4'b0000;
    end
    else if (cmd_valid_i)
    begin
      pin_word_q <= pin_word_i;
    end
  end

  // Bit order of the host word
  assign pins.tck    = pin_word_q[0];
  assign pins.trst_n = pin_word_q[1];
  assign pins.tdi    = pin_word_q[2];
  assign pins.tms    = pin_word_q[3];

  //////////////////////////////////////////////////////////////////////
  // Half-period timer
  //////////////////////////////////////////////////////////////////////

  // Count value k-1 is seen k cycles after the strobe
  assign timer_done    = timer_run_q && (timer_q == HALF_PERIOD - 6'd1);
  assign half_period_o = timer_done;

  // Restart on every strobe, stop after one pulse
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      timer_q     <= 6'd0;
      timer_run_q <= 1'b0;
    end
    else if (cmd_valid_i)
    begin
      timer_q     <= 6'd0;
      timer_run_q <= 1'b1;
    end
    else if (timer_done)
    begin
      timer_run_q <= 1'b0;
    end
    else if (timer_run_q)
    begin
      timer_q <= timer_q + 6'd1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // TDO return
  //////////////////////////////////////////////////////////////////////

  // Change flag lines up with the cycle the new level appears
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      tdo_q        <= 1'b0;
      tdo_change_q <= 1'b0;
    end
    else
    begin
      tdo_q        <= pins.tdo;
      tdo_change_q <= pins.tdo ^ tdo_q;
    end
  end

  assign tdo_o        = tdo_q;
  assign tdo_change_o = tdo_change_q;

endmodule

/* logic/jtag_pins_if.sv */
//////////////////////////////////////////////////////////////////////
// JTAG pin bundle
// TCK, TMS, TDI, TRST and TDO with driver and target modports
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

interface jtag_pins_if;

  // Host side to TAP
  logic tck;
  logic tms;
  logic tdi;
  logic trst_n;

  // TAP back to host side
  logic tdo;

  // Pin driver owns the clock, mode, data and reset pins
  modport driver (
    output tck,
    output tms,
    output tdi,
    output trst_n,
    input  tdo
  );

  // TAP target only returns TDO
  modport target (
    input  tck,
    input  tms,
    input  tdi,
    input  trst_n,
    output tdo
  );

endinterface

/* logic/jtag_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared JTAG definitions
// TAP controller state encoding, instruction codes and register widths
//////////////////////////////////////////////////////////////////////

package jtag_pkg;

  // Register widths
  localparam int IR_WIDTH   = 4;
  localparam int USER_WIDTH = 32;

  // Instruction codes
  localparam logic [IR_WIDTH-1:0] INSTR_IDCODE    = 4'b0001;
  localparam logic [IR_WIDTH-1:0] INSTR_BYPASS    = 4'b1111;
  localparam logic [IR_WIDTH-1:0] INSTR_USER_DATA = 4'b1000;

  // Fixed pattern loaded in Capture-IR, low bits 01 as the standard requires
  localparam logic [IR_WIDTH-1:0] IR_CAPTURE_VALUE = 4'b0001;

  // The 16 TAP controller states
  typedef enum logic [3:0] {
    TAP_TEST_LOGIC_RESET = 4'h0,
    TAP_RUN_TEST_IDLE    = 4'h1,
    TAP_SELECT_DR        = 4'h2,
    TAP_CAPTURE_DR       = 4'h3,
    TAP_SHIFT_DR         = 4'h4,
    TAP_EXIT1_DR         = 4'h5,
    TAP_PAUSE_DR         = 4'h6,
    TAP_EXIT2_DR         = 4'h7,
    TAP_UPDATE_DR        = 4'h8,
    TAP_SELECT_IR        = 4'h9,
    TAP_CAPTURE_IR       = 4'hA,
    TAP_SHIFT_IR         = 4'hB,
    TAP_EXIT1_IR         = 4'hC,
    TAP_PAUSE_IR         = 4'hD,
    TAP_EXIT2_IR         = 4'hE,
    TAP_UPDATE_IR        = 4'hF
  } tap_state_t;

endpackage

/* logic/jtag_scan_regs.sv */
//////////////////////////////////////////////////////////////////////
// JTAG scan registers
// Instruction register, IDCODE, BYPASS and USER_DATA chains
// and the TDO output stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module jtag_scan_regs #(
  parameter logic [31:0] IDCODE_VALUE = 32'h149B_51C3
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  jtag_pins_if.target                       pins,
  input  jtag_pkg::tap_state_t              state_i,
  input  logic                              tck_rise_i,
  input  logic                              tck_fall_i,
  output logic [jtag_pkg::USER_WIDTH-1:0]   user_data_o,
  output logic                              user_update_o
);

  import jtag_pkg::*;

  logic [IR_WIDTH-1:0]   ir_q;
  logic [IR_WIDTH-1:0]   ir_sr_q;
  logic [31:0]           idcode_sr_q;
  logic                  bypass_q;
  logic [USER_WIDTH-1:0] user_sr_q;
  logic [USER_WIDTH-1:0] user_q;
  logic                  user_update_q;
  logic                  rise_d_q;
  logic                  tdo_q;
  logic                  sel_idcode;
  logic                  sel_user;
  logic                  dr_lsb;

  //////////////////////////////////////////////////////////////////////
  // Instruction decode
  //////////////////////////////////////////////////////////////////////

  // Any code that is not defined falls through to BYPASS
  assign sel_idcode = (ir_q == INSTR_IDCODE);
  assign sel_user   = (ir_q == INSTR_USER_DATA);

  // Low bit of whichever data register sits between TDI and TDO
  always_comb
  begin
    if (sel_idcode)
    begin
      dr_lsb = idcode_sr_q[0];
    end
    else if (sel_user)
    begin
      dr_lsb = user_sr_q[0];
    end
    else
    begin
      dr_lsb = bypass_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Shift chains
  //////////////////////////////////////////////////////////////////////

  // Capture and shift act on the state held before the rise
  always_ff @(posedge clk_i)
  begin
    if (tck_rise_i)
    begin
      case (state_i)
        TAP_CAPTURE_IR: ir_sr_q <= IR_CAPTURE_VALUE;
        TAP_SHIFT_IR:   ir_sr_q <= {pins.tdi, ir_sr_q[IR_WIDTH-1:1]};
        default:        ir_sr_q <= ir_sr_q;
      endcase
    end
  end

  // All data chains load at once, only the selected one shifts
  always_ff @(posedge clk_i)
  begin
    if (tck_rise_i && state_i == TAP_CAPTURE_DR)
    begin
      idcode_sr_q <= IDCODE_VALUE;
      user_sr_q   <= user_q;
      bypass_q    <= 1'b0;
    end
    else if (tck_rise_i && state_i == TAP_SHIFT_DR)
    begin
      if (sel_idcode)
      begin
        idcode_sr_q <= {pins.tdi, idcode_sr_q[31:1]};
      end
      else if (sel_user)
      begin
        user_sr_q <= {pins.tdi, user_sr_q[USER_WIDTH-1:1]};
      end
      else
      begin
        bypass_q <= pins.tdi;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Update stage
  //////////////////////////////////////////////////////////////////////

  // rise_d_q marks the first cycle of the state just entered
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rise_d_q      <= 1'b0;
      ir_q          <= INSTR_IDCODE;
      user_q        <= '0;
      user_update_q <= 1'b0;
    end
    else
    begin
      rise_d_q      <= tck_rise_i;
      user_update_q <= 1'b0;
      // Test-Logic-Reset, also reached through TRST, reselects IDCODE
      if (state_i == TAP_TEST_LOGIC_RESET)
      begin
        ir_q <= INSTR_IDCODE;
      end
      else if (rise_d_q && state_i == TAP_UPDATE_IR)
      begin
        ir_q <= ir_sr_q;
      end
      if (rise_d_q && state_i == TAP_UPDATE_DR && sel_user)
      begin
        user_q        <= user_sr_q;
        user_update_q <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // TDO output stage
  //////////////////////////////////////////////////////////////////////

  // Changes on TCK falls only, zero outside the shift states
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      tdo_q <= 1'b0;
    end
    else if (tck_fall_i)
    begin
      case (state_i)
        TAP_SHIFT_IR: tdo_q <= ir_sr_q[0];
        TAP_SHIFT_DR: tdo_q <= dr_lsb;
        default:      tdo_q <= 1'b0;
      endcase
    end
  end

  assign pins.tdo      = tdo_q;
  assign user_data_o   = user_q;
  assign user_update_o = user_update_q;

endmodule

/* logic/jtag_tap_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// JTAG TAP controller
// TCK and TRST oversampling, edge strobes and the 16-state FSM
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module jtag_tap_ctrl (
  input  logic               clk_i,
  input  logic               rst_n_i,
  jtag_pins_if.target        pins,
  output jtag_pkg::tap_state_t state_o,
  output logic               tck_rise_o,
  output logic               tck_fall_o
);

  import jtag_pkg::*;

  logic       tck_s1_q;
  logic       tck_s2_q;
  logic       trst_n_s1_q;
  logic       trst_n_s2_q;
  logic       tck_rise_q;
  logic       tck_fall_q;
  tap_state_t state_q;
  tap_state_t state_next;

  //////////////////////////////////////////////////////////////////////
  // Pin sampling and edge detect
  //////////////////////////////////////////////////////////////////////

  // Two sample stages, then a registered edge strobe
  // so an edge shows two cycles after the pin moves
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      tck_s1_q    <= 1'b0;
      tck_s2_q    <= 1'b0;
      trst_n_s1_q <= 1'b0;
      trst_n_s2_q <= 1'b0;
      tck_rise_q  <= 1'b0;
      tck_fall_q  <= 1'b0;
    end
    else
    begin
      tck_s1_q    <= pins.tck;
      tck_s2_q    <= tck_s1_q;
      trst_n_s1_q <= pins.trst_n;
      trst_n_s2_q <= trst_n_s1_q;
      tck_rise_q  <= tck_s1_q & ~tck_s2_q;
      tck_fall_q  <= ~tck_s1_q & tck_s2_q;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // TAP state machine
  //////////////////////////////////////////////////////////////////////

  // Standard transitions, TMS picks the branch
  always_comb
  begin
    state_next = state_q;
    case (state_q)
      TAP_TEST_LOGIC_RESET: state_next = pins.tms ? TAP_TEST_LOGIC_RESET : TAP_RUN_TEST_IDLE;
      TAP_RUN_TEST_IDLE:    state_next = pins.tms ? TAP_SELECT_DR : TAP_RUN_TEST_IDLE;
      TAP_SELECT_DR:        state_next = pins.tms ? TAP_SELECT_IR : TAP_CAPTURE_DR;
      TAP_CAPTURE_DR:       state_next = pins.tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
      TAP_SHIFT_DR:         state_next = pins.tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
      TAP_EXIT1_DR:         state_next = pins.tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
      TAP_PAUSE_DR:         state_next = pins.tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
      TAP_EXIT2_DR:         state_next = pins.tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
      TAP_UPDATE_DR:        state_next = pins.tms ? TAP_SELECT_DR : TAP_RUN_TEST_IDLE;
      // IR column mirrors the DR column
      TAP_SELECT_IR:        state_next = pins.tms ? TAP_TEST_LOGIC_RESET : TAP_CAPTURE_IR;
      TAP_CAPTURE_IR:       state_next = pins.tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
      TAP_SHIFT_IR:         state_next = pins.tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
      TAP_EXIT1_IR:         state_next = pins.tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
      TAP_PAUSE_IR:         state_next = pins.tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
      TAP_EXIT2_IR:         state_next = pins.tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
      TAP_UPDATE_IR:        state_next = pins.tms ? TAP_SELECT_DR : TAP_RUN_TEST_IDLE;
      default:              state_next = TAP_TEST_LOGIC_RESET;
    endcase
  end

  // Low TRST overrides everything, otherwise step on TCK rises
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= TAP_TEST_LOGIC_RESET;
    end
    else if (!trst_n_s2_q)
    begin
      state_q <= TAP_TEST_LOGIC_RESET;
    end
    else if (tck_rise_q)
    begin
      state_q <= state_next;
    end
  end

  assign state_o    = state_q;
  assign tck_rise_o = tck_rise_q;
  assign tck_fall_o = tck_fall_q;

endmodule

/* testbench/jtag_bridge_checker.sv */
//////////////////////////////////////////////////////////////////////
// JTAG bridge checker
// Watches the top-level ports, keeps a TAP model fed from the
// host pin words and counts checks and errors
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module jtag_bridge_checker #(
  parameter logic [5:0] HALF_PERIOD = 6'd8
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            cmd_valid_i,
  input  logic [3:0]                      pin_word_i,
  input  logic                            half_period_i,
  input  logic                            tdo_i,
  input  logic                            tdo_change_i,
  input  logic [jtag_pkg::USER_WIDTH-1:0] user_data_i,
  input  logic                            user_update_i,
  input  logic                            exp_tdo_valid_i,
  input  logic                            exp_user_valid_i,
  input  logic [31:0]                     exp_value_i,
  output int                              error_count_o,
  output int                              check_count_o
);

  import jtag_pkg::*;

  // Stages from the strobe edge to user_update_o are the word register,
  // first sampler, edge flag, state register and update flag
  localparam int UPDATE_DELAY = 5;

  // TAP model
  tap_state_t  state_m;
  logic [3:0]  word_m;
  logic [3:0]  ir_m;
  logic [3:0]  ir_sr_m;
  logic [31:0] user_m;
  logic [31:0] user_sr_m;

  // Timing bookkeeping
  int   since;
  int   since_n;
  logic armed;
  logic update_pending;
  logic prev_tdo;
  int   errors = 0;
  int   checks = 0;

  assign error_count_o = errors;
  assign check_count_o = checks;

  task automatic compare_bit(input string name, input logic got, input logic expected);
    checks++;
    if (got !== expected)
    begin
      errors++;
      $display("ERROR at %0t ns: %s = %b, expected %b", $time, name, got, expected);
    end
  endtask

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
    checks++;
    if (got !== expected)
    begin
      errors++;
      $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, expected);
    end
  endtask

  // Standard TAP diagram with TMS sampled on the TCK rise
  function automatic tap_state_t tap_next(input tap_state_t s, input logic tms);
    case (s)
      TAP_TEST_LOGIC_RESET: return tms ? TAP_TEST_LOGIC_RESET : TAP_RUN_TEST_IDLE;
      TAP_RUN_TEST_IDLE:    return tms ? TAP_SELECT_DR : TAP_RUN_TEST_IDLE;
      TAP_SELECT_DR:        return tms ? TAP_SELECT_IR : TAP_CAPTURE_DR;
      TAP_CAPTURE_DR:       return tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
      TAP_SHIFT_DR:         return tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
      TAP_EXIT1_DR:         return tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
      TAP_PAUSE_DR:         return tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
      TAP_EXIT2_DR:         return tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
      TAP_UPDATE_DR:        return tms ? TAP_SELECT_DR : TAP_RUN_TEST_IDLE;
      TAP_SELECT_IR:        return tms ? TAP_TEST_LOGIC_RESET : TAP_CAPTURE_IR;
      TAP_CAPTURE_IR:       return tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
      TAP_SHIFT_IR:         return tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
      TAP_EXIT1_IR:         return tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
      TAP_PAUSE_IR:         return tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
      TAP_EXIT2_IR:         return tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
      default:              return tms ? TAP_SELECT_DR : TAP_RUN_TEST_IDLE;
    endcase
  endfunction

  // Apply one host word to the model
  task automatic step_model(input logic [3:0] w);
    if (!w[1])
    begin
      state_m = TAP_TEST_LOGIC_RESET;
      ir_m    = INSTR_IDCODE;
    end
    else if (w[0] && !word_m[0])
    begin
      // Capture and shift use the state before the rise
      case (state_m)
        TAP_CAPTURE_IR: ir_sr_m = 4'b0001;
        TAP_SHIFT_IR:   ir_sr_m = {w[2], ir_sr_m[3:1]};
        TAP_CAPTURE_DR: user_sr_m = user_m;
        TAP_SHIFT_DR:
        begin
          if (ir_m == INSTR_USER_DATA)
            user_sr_m = {w[2], user_sr_m[31:1]};
        end
        default:        ;
      endcase
      state_m = tap_next(state_m, w[3]);
      if (state_m == TAP_UPDATE_IR)
        ir_m = ir_sr_m;
      if (state_m == TAP_TEST_LOGIC_RESET)
        ir_m = INSTR_IDCODE;
      if (state_m == TAP_UPDATE_DR && ir_m == INSTR_USER_DATA)
      begin
        user_m         = user_sr_m;
        update_pending = 1'b1;
      end
    end
    word_m = w;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Per-cycle checks
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_m        = TAP_TEST_LOGIC_RESET;
      word_m         = 4'b0000;
      ir_m           = INSTR_IDCODE;
      ir_sr_m        = 4'b0000;
      user_m         = 32'd0;
      user_sr_m      = 32'd0;
      since          = 0;
      armed          = 1'b0;
      update_pending = 1'b0;
      prev_tdo       = 1'b0;
    end
    else
    begin
      since_n = since + 1;
      // One timer pulse HALF_PERIOD cycles after the last strobe
      compare_bit("half_period_o", half_period_i, armed && (since_n == HALF_PERIOD));
      compare_bit("tdo_change_o", tdo_change_i, tdo_i ^ prev_tdo);
      compare_bit("user_update_o", user_update_i,
                  update_pending && (since_n == UPDATE_DELAY));
      if (update_pending && since_n == UPDATE_DELAY)
      begin
        compare_word("user_data_o", user_data_i, user_m);
        update_pending = 1'b0;
      end
      // Expected values from the stimulus table
      if (exp_tdo_valid_i)
        compare_bit("tdo_o", tdo_i, exp_value_i[0]);
      if (exp_user_valid_i)
        compare_word("user_data_o", user_data_i, exp_value_i);
      prev_tdo = tdo_i;
      if (cmd_valid_i)
      begin
        since = 0;
        armed = 1'b1;
        step_model(pin_word_i);
      end
      else
      begin
        since = since_n;
      end
    end
  end

endmodule

/* testbench/tb_jtag_bridge.sv */
//////////////////////////////////////////////////////////////////////
// JTAG bridge testbench
// Clock, reset, stimulus table with scan helpers, watchdog,
// DUT and checker instances
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_jtag_bridge;

  import jtag_pkg::*;

  localparam logic [5:0]  HALF_PERIOD  = 6'd8;
  localparam logic [31:0] IDCODE_VALUE = 32'h4BA0_0477;
  localparam int          MARGIN_NS    = 2000;

  // Row kinds
  localparam logic [1:0] ROW_PINS = 2'd0;
  localparam logic [1:0] ROW_TDO  = 2'd1;
  localparam logic [1:0] ROW_USER = 2'd2;

  // Pin word with a wait or an expected observation in value
  typedef struct packed {
    logic [1:0]  kind;
    logic [3:0]  word;
    logic [7:0]  wait_cycles;
    logic [31:0] value;
  } row_t;

  logic        clk_i;
  logic        rst_n_i;
  logic        cmd_valid_i;
  logic [3:0]  pin_word_i;
  logic        half_period_o;
  logic        tdo_o;
  logic        tdo_change_o;
  logic [31:0] user_data_o;
  logic        user_update_o;
  logic        exp_tdo_valid;
  logic        exp_user_valid;
  logic [31:0] exp_value;
  int          error_count;
  int          check_count;
  row_t        rows[$];
  logic        table_ready;
  integer      seed;
  logic [31:0] user_word;

  jtag_bridge_top #(
    .HALF_PERIOD   (HALF_PERIOD),
    .IDCODE_VALUE  (IDCODE_VALUE)
  ) dut0 (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cmd_valid_i   (cmd_valid_i),
    .pin_word_i    (pin_word_i),
    .half_period_o (half_period_o),
    .tdo_o         (tdo_o),
    .tdo_change_o  (tdo_change_o),
    .user_data_o   (user_data_o),
    .user_update_o (user_update_o)
  );

  jtag_bridge_checker #(
    .HALF_PERIOD      (HALF_PERIOD)
  ) chk0 (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .cmd_valid_i      (cmd_valid_i),
    .pin_word_i       (pin_word_i),
    .half_period_i    (half_period_o),
    .tdo_i            (tdo_o),
    .tdo_change_i     (tdo_change_o),
    .user_data_i      (user_data_o),
    .user_update_i    (user_update_o),
    .exp_tdo_valid_i  (exp_tdo_valid),
    .exp_user_valid_i (exp_user_valid),
    .exp_value_i      (exp_value),
    .error_count_o    (error_count),
    .check_count_o    (check_count)
  );

  // 4 ns clock
  initial
  begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Table builders
  //////////////////////////////////////////////////////////////////////

  // Host bit order is tck, trst_n, tdi and tms from bit 0 up
  function automatic logic [3:0] make_word(input logic tck, input logic trst_n,
                                           input logic tdi, input logic tms);
    return {tms, tdi, trst_n, tck};
  endfunction

  // Zero wait means hold until half_period_o
  task automatic add_pins(input logic [3:0] word, input logic [7:0] wait_cycles);
    row_t r;
    r.kind        = ROW_PINS;
    r.word        = word;
    r.wait_cycles = wait_cycles;
    r.value       = 32'd0;
    rows.push_back(r);
  endtask

  task automatic add_expect(input logic [1:0] kind, input logic [31:0] value);
    row_t r;
    r.kind        = kind;
    r.word        = 4'd0;
    r.wait_cycles = 8'd0;
    r.value       = value;
    rows.push_back(r);
  endtask

  // One TCK period with TDO checked after the falling half
  task automatic tck_cycle(input logic tms, input logic tdi, input logic check,
                           input logic exp_bit);
    add_pins(make_word(1'b0, 1'b1, tdi, tms), 8'd0);
    if (check)
      add_expect(ROW_TDO, {31'd0, exp_bit});
    add_pins(make_word(1'b1, 1'b1, tdi, tms), 8'd0);
  endtask

  task automatic move_tms(input logic tms);
    tck_cycle(tms, 1'b0, 1'b0, 1'b0);
  endtask

  // TRST pulse and five TMS-high clocks ending in Run-Test/Idle
  task automatic reset_tap();
    add_pins(make_word(1'b0, 1'b0, 1'b0, 1'b0), 8'd0);
    add_pins(make_word(1'b1, 1'b0, 1'b0, 1'b0), 8'd0);
    add_pins(make_word(1'b0, 1'b0, 1'b0, 1'b0), 8'd0);
    repeat (5) move_tms(1'b1);
    move_tms(1'b0);
  endtask

  // IR scan from Run-Test/Idle back to Run-Test/Idle shifting capture pattern 0001 out
  task automatic scan_ir(input logic [3:0] code);
    logic [3:0] capture_bits;
    capture_bits = 4'b0001;
    move_tms(1'b1);
    move_tms(1'b1);
    move_tms(1'b0);
    move_tms(1'b0);
    for (int i = 0; i < 4; i++)
      tck_cycle(i == 3, code[i], 1'b1, capture_bits[i]);
    move_tms(1'b1);
    move_tms(1'b0);
  endtask

  // DR scan low bit first where the last bit leaves Shift-DR
  task automatic scan_dr(input int length, input logic [31:0] data_in,
                         input logic [31:0] data_out);
    move_tms(1'b1);
    move_tms(1'b0);
    move_tms(1'b0);
    for (int i = 0; i < length; i++)
      tck_cycle(i == length - 1, data_in[i], 1'b1, data_out[i]);
    move_tms(1'b1);
    move_tms(1'b0);
  endtask

  task automatic build_table();
    // Timer restart by an early strobe followed by a full count
    add_pins(make_word(1'b0, 1'b0, 1'b0, 1'b0), 8'd3);
    add_pins(make_word(1'b0, 1'b0, 1'b0, 1'b0), 8'd0);
    // IDCODE selected after reset
    reset_tap();
    scan_dr(32, 32'd0, IDCODE_VALUE);
    // BYPASS delays TDI by one TCK
    scan_ir(INSTR_BYPASS);
    scan_dr(8, 32'h0000_00B2, 32'h0000_00B2 << 1);
    // USER_DATA write and read back
    user_word = $random(seed);
    scan_ir(INSTR_USER_DATA);
    scan_dr(32, user_word, 32'd0);
    add_expect(ROW_USER, user_word);
    scan_dr(32, ~user_word, user_word);
    add_expect(ROW_USER, ~user_word);
    // Undefined code acts as BYPASS
    scan_ir(4'b0101);
    scan_dr(8, 32'h0000_005A, 32'h0000_005A << 1);
    // Reset reselects IDCODE
    reset_tap();
    scan_dr(32, 32'hFFFF_FFFF, IDCODE_VALUE);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Table replay
  //////////////////////////////////////////////////////////////////////

  task automatic apply_row(input row_t r);
    if (r.kind == ROW_PINS)
    begin
      @(posedge clk_i);
      cmd_valid_i <= 1'b1;
      pin_word_i  <= r.word;
      @(posedge clk_i);
      cmd_valid_i <= 1'b0;
      if (r.wait_cycles != 8'd0)
        repeat (r.wait_cycles) @(posedge clk_i);
      else
        while (!half_period_o) @(posedge clk_i);
    end
    else
    begin
      @(posedge clk_i);
      exp_tdo_valid  <= (r.kind == ROW_TDO);
      exp_user_valid <= (r.kind == ROW_USER);
      exp_value      <= r.value;
      @(posedge clk_i);
      exp_tdo_valid  <= 1'b0;
      exp_user_valid <= 1'b0;
    end
  endtask

  initial
  begin
    table_ready    = 1'b0;
    rst_n_i        = 1'b0;
    cmd_valid_i    = 1'b0;
    pin_word_i     = 4'b0000;
    exp_tdo_valid  = 1'b0;
    exp_user_valid = 1'b0;
    exp_value      = 32'd0;
    seed           = 28;
    build_table();
    table_ready = 1'b1;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    for (int i = 0; i < rows.size(); i++)
      apply_row(rows[i]);
    repeat (4) @(posedge clk_i);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  // Watchdog sized from the table length
  initial
  begin
    wait (table_ready === 1'b1);
    #(rows.size() * (int'(HALF_PERIOD) + 4) * 4 + MARGIN_NS);
    $display("Timeout: the stimulus table did not complete in time");
    $display("Finished with errors");
    $finish;
  end

endmodule

/* verilog.f */
logic/jtag_pkg.sv
logic/jtag_pins_if.sv
logic/jtag_pin_driver.sv
logic/jtag_tap_ctrl.sv
logic/jtag_scan_regs.sv
logic/jtag_bridge_top.sv
testbench/jtag_bridge_checker.sv
testbench/tb_jtag_bridge.sv
